// File: src/edge_pkg.sv
/*
 * shared definitions for the edge job unit
 *   entry, line and address widths with their typedefs
 *   command and edge queue depths, response counter width
 *   array select enum and request FSM states
 */
`default_nettype none

package edge_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int EDGE_BYTES      = 4;
	localparam int LINE_BYTES      = 16;
	localparam int LINE_EDGES      = LINE_BYTES / EDGE_BYTES;
	localparam int CMD_FIFO_DEPTH  = 4;
	localparam int EDGE_FIFO_DEPTH = 16;
	// enough for the three reads of one chunk
	localparam int OUTSTANDING_W   = 4;

	//////////////////////////////////////////////////
	// typed vectors
	//////////////////////////////////////////////////
	typedef logic [31:0]                     addr_t;
	typedef logic [31:0]                     edge_word_t;
	// entry 0 in the low bits
	typedef logic [LINE_BYTES*8-1:0]         line_t;
	typedef logic [15:0]                     edge_count_t;
	typedef logic [$clog2(LINE_EDGES)-1:0]   line_slot_t;
	typedef logic [2:0]                      chunk_count_t;
	typedef logic [15:0]                     edge_id_t;

	typedef enum logic [1:0] {
		ARRAY_SRC    = 2'd0,
		ARRAY_DEST   = 2'd1,
		ARRAY_WEIGHT = 2'd2
	} array_sel_t;

	typedef enum logic [2:0] {
		REQ_IDLE       = 3'd0,
		REQ_LOAD       = 3'd1,
		REQ_WAIT       = 3'd2,
		REQ_SIZE       = 3'd3,
		REQ_CMD_SRC    = 3'd4,
		REQ_CMD_DEST   = 3'd5,
		REQ_CMD_WEIGHT = 3'd6
	} req_state_t;

	// queue words: array tag above address, id above src, dest, weight
	typedef logic [$bits(array_sel_t)+$bits(addr_t)-1:0] cmd_entry_t;
	typedef logic [$bits(edge_id_t)+3*$bits(edge_word_t)-1:0] edge_record_t;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
/*
 * synchronous first-word-fall-through queue
 *   circular buffer with an entry count
 *   almost-full flag at a set gap below depth
 */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int WIDTH      = 32,
	parameter int DEPTH      = 4,
	parameter int ALFULL_GAP = 1
) (
	input  wire              clock,
	input  wire              rstn,
	input  wire              push,
	input  wire [WIDTH-1:0]  data_in,
	input  wire              pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty,
	output logic             alfull
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	// wraps for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && (count != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	assign data_out = mem[rd_ptr];
	assign valid    = (count != '0);
	assign empty    = (count == '0);
	assign alfull   = (count >= CNT_W'(DEPTH - ALFULL_GAP));

	// producer must respect the almost-full gap
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full);

endmodule

`default_nettype wire

// File: src/edge_request_gen.sv
/*
 * request generator
 *   vertex job acceptance with repeat filtering
 *   chunking FSM, one chunk per cacheline
 *   outstanding read response counter
 */
`timescale 1ns/1ns
`default_nettype none

module edge_request_gen (
	input  wire                        clock,
	input  wire                        rstn,
	input  wire                        vertex_valid,
	input  wire edge_pkg::edge_count_t vertex_id,
	input  wire edge_pkg::edge_count_t vertex_edge_idx,
	input  wire edge_pkg::edge_count_t vertex_degree,
	input  wire edge_pkg::addr_t       src_base,
	input  wire edge_pkg::addr_t       dest_base,
	input  wire edge_pkg::addr_t       weight_base,
	input  wire                        cmd_push_ok,
	input  wire                        edge_room,
	input  wire                        unpack_busy,
	input  wire                        read_resp_valid,
	output logic                       idle,
	output logic                       cmd_push,
	output edge_pkg::addr_t            cmd_addr,
	output edge_pkg::array_sel_t       cmd_array,
	output logic                       chunk_start,
	output edge_pkg::line_slot_t       chunk_slot,
	output edge_pkg::chunk_count_t     chunk_count,
	output logic                       responses_in
);
	import edge_pkg::*;

	req_state_t               state, next_state;
	logic                     have_last;
	logic                     accept;
	edge_count_t              last_id;
	edge_count_t              job_idx;
	edge_count_t              job_degree;
	edge_count_t              remaining;
	addr_t                    next_offset;
	addr_t                    line_offset;
	line_slot_t               size_slot;
	edge_count_t              size_room;
	edge_count_t              size_count;
	logic [OUTSTANDING_W-1:0] outstanding;

	// new id only, or the first job after reset
	assign accept = vertex_valid && (state == REQ_IDLE) && (!have_last || vertex_id != last_id);

	// chunk ends at the line boundary or at the last edge
	always_comb begin
		size_slot  = line_slot_t'((next_offset % LINE_BYTES) / EDGE_BYTES);
		size_room  = edge_count_t'(LINE_EDGES) - edge_count_t'(size_slot);
		size_count = (remaining < size_room) ? remaining : size_room;
	end

	//////////////////////////////////////////////////
	// chunking FSM
	//////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			REQ_IDLE: begin
				if (accept)
					next_state = REQ_LOAD;
			end
			REQ_LOAD: begin
				next_state = (job_degree == '0) ? REQ_IDLE : REQ_WAIT;
			end
			REQ_WAIT: begin
				if (outstanding == '0 && !unpack_busy && cmd_push_ok && edge_room)
					next_state = REQ_SIZE;
			end
			REQ_SIZE:       next_state = REQ_CMD_SRC;
			REQ_CMD_SRC:    next_state = REQ_CMD_DEST;
			REQ_CMD_DEST:   next_state = REQ_CMD_WEIGHT;
			REQ_CMD_WEIGHT: next_state = (remaining == '0) ? REQ_IDLE : REQ_WAIT;
			default:        next_state = REQ_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= REQ_IDLE;
			have_last <= 1'b0;
			remaining <= '0;
		end else begin
			state <= next_state;
			if (accept)
				have_last <= 1'b1;
			if (state == REQ_LOAD)
				remaining <= job_degree;
			else if (state == REQ_SIZE)
				remaining <= remaining - size_count;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			last_id    <= vertex_id;
			job_idx    <= vertex_edge_idx;
			job_degree <= vertex_degree;
		end
		if (state == REQ_LOAD)
			next_offset <= addr_t'(job_idx) * EDGE_BYTES;
		if (state == REQ_SIZE) begin
			line_offset <= next_offset - (next_offset % LINE_BYTES);
			next_offset <= next_offset - (next_offset % LINE_BYTES) + LINE_BYTES;
			chunk_slot  <= size_slot;
			chunk_count <= chunk_count_t'(size_count);
		end
	end

	// one command per array state, src first
	always_comb begin
		cmd_push  = 1'b0;
		cmd_array = ARRAY_SRC;
		cmd_addr  = src_base + line_offset;
		case (state)
			REQ_CMD_SRC: begin
				cmd_push = 1'b1;
			end
			REQ_CMD_DEST: begin
				cmd_push  = 1'b1;
				cmd_array = ARRAY_DEST;
				cmd_addr  = dest_base + line_offset;
			end
			REQ_CMD_WEIGHT: begin
				cmd_push  = 1'b1;
				cmd_array = ARRAY_WEIGHT;
				cmd_addr  = weight_base + line_offset;
			end
			default: ;
		endcase
	end

	assign idle        = (state == REQ_IDLE);
	assign chunk_start = (state == REQ_CMD_SRC);

	//////////////////////////////////////////////////
	// outstanding responses
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({cmd_push, read_resp_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	assign responses_in = (outstanding == '0);

	// memory answers only what was asked, at most one chunk in flight
	assert property (@(posedge clock) disable iff (!rstn)
		!(read_resp_valid && !cmd_push && outstanding == '0));
	assert property (@(posedge clock) disable iff (!rstn) outstanding <= 3);

endmodule

`default_nettype wire

// File: src/cacheline_unpacker.sv
/*
 * cacheline unpacker for one array
 *   captures the line tagged with its array
 *   shifts the chunk's entries out one per cycle
 */
`timescale 1ns/1ns
`default_nettype none

module cacheline_unpacker (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire edge_pkg::array_sel_t   array,
	input  wire                         chunk_start,
	input  wire edge_pkg::line_slot_t   chunk_slot,
	input  wire edge_pkg::chunk_count_t chunk_count,
	input  wire                         read_resp_valid,
	input  wire edge_pkg::array_sel_t   read_resp_array,
	input  wire edge_pkg::line_t        read_resp_data,
	input  wire                         responses_in,
	output logic                        busy,
	output logic                        entry_valid,
	output edge_pkg::edge_word_t        entry
);
	import edge_pkg::*;

	logic         held;
	logic         capture;
	logic         shift;
	line_slot_t   slot;
	chunk_count_t left;
	line_t        line_q;

	assign capture = read_resp_valid && (read_resp_array == array) && busy && !held;
	// wait for all three arrays so the unpackers run in lockstep
	assign shift   = held && responses_in;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
			held <= 1'b0;
			slot <= '0;
			left <= '0;
		end else if (chunk_start) begin
			busy <= 1'b1;
			held <= 1'b0;
			slot <= chunk_slot;
			left <= chunk_count;
		end else begin
			if (capture)
				held <= 1'b1;
			if (shift) begin
				slot <= line_slot_t'(slot + 1'b1);
				left <= left - 1'b1;
				// last entry of the chunk
				if (left == chunk_count_t'(1)) begin
					busy <= 1'b0;
					held <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (capture)
			line_q <= read_resp_data;
	end

	assign entry_valid = shift;
	assign entry       = line_q[slot*$bits(edge_word_t) +: $bits(edge_word_t)];

	// one response per array per chunk
	assert property (@(posedge clock) disable iff (!rstn)
		!(read_resp_valid && read_resp_array == array && held));

endmodule

`default_nettype wire

// File: src/edge_assembler.sv
/*
 * edge assembler
 *   joins src, dest and weight entries
 *   tags each record with a running edge id
 */
`timescale 1ns/1ns
`default_nettype none

module edge_assembler (
	input  wire                       clock,
	input  wire                       rstn,
	input  wire                       src_valid,
	input  wire edge_pkg::edge_word_t src_entry,
	input  wire                       dest_valid,
	input  wire edge_pkg::edge_word_t dest_entry,
	input  wire                       weight_valid,
	input  wire edge_pkg::edge_word_t weight_entry,
	output logic                      push,
	output edge_pkg::edge_record_t    record
);
	import edge_pkg::*;

	logic     all_valid;
	edge_id_t next_id;

	assign all_valid = src_valid && dest_valid && weight_valid;

	// id keeps counting across vertices
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push    <= 1'b0;
			next_id <= '0;
		end else begin
			push <= all_valid;
			if (all_valid)
				next_id <= next_id + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (all_valid)
			record <= {next_id, src_entry, dest_entry, weight_entry};
	end

	// unpackers share chunk and response timing
	assert property (@(posedge clock) disable iff (!rstn)
		(src_valid == dest_valid) && (dest_valid == weight_valid));

endmodule

`default_nettype wire

// File: src/edge_job_control.sv
/*
 * edge job unit top level
 *   request generator with its command queue
 *   one cacheline unpacker per array
 *   edge assembler feeding the edge queue
 */
`timescale 1ns/1ns
`default_nettype none

module edge_job_control (
	input  wire                       clock,
	input  wire                       rstn,
	input  wire                       vertex_valid,
	input  wire edge_pkg::edge_count_t vertex_id,
	input  wire edge_pkg::edge_count_t vertex_edge_idx,
	input  wire edge_pkg::edge_count_t vertex_degree,
	input  wire edge_pkg::addr_t      src_base,
	input  wire edge_pkg::addr_t      dest_base,
	input  wire edge_pkg::addr_t      weight_base,
	input  wire                       mem_busy,
	input  wire                       read_resp_valid,
	input  wire edge_pkg::array_sel_t read_resp_array,
	input  wire edge_pkg::line_t      read_resp_data,
	input  wire                       edge_request,
	output logic                      idle,
	output logic                      read_cmd_valid,
	output edge_pkg::addr_t           read_cmd_addr,
	output edge_pkg::array_sel_t      read_cmd_array,
	output logic                      edge_valid,
	output edge_pkg::edge_id_t        edge_id,
	output edge_pkg::edge_word_t      edge_src,
	output edge_pkg::edge_word_t      edge_dest,
	output edge_pkg::edge_word_t      edge_weight
);
	import edge_pkg::*;

	logic         cmd_push;
	addr_t        cmd_addr;
	array_sel_t   cmd_array;
	logic         cmd_empty;
	logic         cmd_valid;
	cmd_entry_t   cmd_head;
	logic         chunk_start;
	line_slot_t   chunk_slot;
	chunk_count_t chunk_count;
	logic         responses_in;
	logic         src_busy, dest_busy, weight_busy;
	logic         unpack_busy;
	logic         src_valid, dest_valid, weight_valid;
	edge_word_t   src_entry, dest_entry, weight_entry;
	logic         asm_push;
	edge_record_t asm_record;
	edge_record_t edge_head;
	logic         edge_alfull;

	assign unpack_busy = src_busy || dest_busy || weight_busy;

	//////////////////////////////////////////////////
	// chunk requests and the command queue
	//////////////////////////////////////////////////
	edge_request_gen u_request_gen (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_valid   (vertex_valid),
		.vertex_id      (vertex_id),
		.vertex_edge_idx(vertex_edge_idx),
		.vertex_degree  (vertex_degree),
		.src_base       (src_base),
		.dest_base      (dest_base),
		.weight_base    (weight_base),
		.cmd_push_ok    (cmd_empty),
		.edge_room      (!edge_alfull),
		.unpack_busy    (unpack_busy),
		.read_resp_valid(read_resp_valid),
		.idle           (idle),
		.cmd_push       (cmd_push),
		.cmd_addr       (cmd_addr),
		.cmd_array      (cmd_array),
		.chunk_start    (chunk_start),
		.chunk_slot     (chunk_slot),
		.chunk_count    (chunk_count),
		.responses_in   (responses_in)
	);

	// head is held while memory is busy
	sync_fifo #(
		.WIDTH     ($bits(cmd_entry_t)),
		.DEPTH     (CMD_FIFO_DEPTH),
		.ALFULL_GAP(1)
	) u_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in ({cmd_array, cmd_addr}),
		.pop     (!mem_busy),
		.data_out(cmd_head),
		.valid   (cmd_valid),
		.empty   (cmd_empty),
		.alfull  ()
	);

	assign read_cmd_valid = cmd_valid && !mem_busy;
	assign read_cmd_addr  = cmd_head[$bits(addr_t)-1:0];
	assign read_cmd_array = array_sel_t'(cmd_head[$bits(cmd_entry_t)-1:$bits(addr_t)]);

	//////////////////////////////////////////////////
	// line unpackers, one per array
	//////////////////////////////////////////////////
	cacheline_unpacker u_unpack_src (
		.clock          (clock),
		.rstn           (rstn),
		.array          (ARRAY_SRC),
		.chunk_start    (chunk_start),
		.chunk_slot     (chunk_slot),
		.chunk_count    (chunk_count),
		.read_resp_valid(read_resp_valid),
		.read_resp_array(read_resp_array),
		.read_resp_data (read_resp_data),
		.responses_in   (responses_in),
		.busy           (src_busy),
		.entry_valid    (src_valid),
		.entry          (src_entry)
	);

	cacheline_unpacker u_unpack_dest (
		.clock          (clock),
		.rstn           (rstn),
		.array          (ARRAY_DEST),
		.chunk_start    (chunk_start),
		.chunk_slot     (chunk_slot),
		.chunk_count    (chunk_count),
		.read_resp_valid(read_resp_valid),
		.read_resp_array(read_resp_array),
		.read_resp_data (read_resp_data),
		.responses_in   (responses_in),
		.busy           (dest_busy),
		.entry_valid    (dest_valid),
		.entry          (dest_entry)
	);

	cacheline_unpacker u_unpack_weight (
		.clock          (clock),
		.rstn           (rstn),
		.array          (ARRAY_WEIGHT),
		.chunk_start    (chunk_start),
		.chunk_slot     (chunk_slot),
		.chunk_count    (chunk_count),
		.read_resp_valid(read_resp_valid),
		.read_resp_array(read_resp_array),
		.read_resp_data (read_resp_data),
		.responses_in   (responses_in),
		.busy           (weight_busy),
		.entry_valid    (weight_valid),
		.entry          (weight_entry)
	);

	//////////////////////////////////////////////////
	// edge records and the edge queue
	//////////////////////////////////////////////////
	edge_assembler u_assembler (
		.clock       (clock),
		.rstn        (rstn),
		.src_valid   (src_valid),
		.src_entry   (src_entry),
		.dest_valid  (dest_valid),
		.dest_entry  (dest_entry),
		.weight_valid(weight_valid),
		.weight_entry(weight_entry),
		.push        (asm_push),
		.record      (asm_record)
	);

	// gap of one chunk keeps in-flight edges safe
	sync_fifo #(
		.WIDTH     ($bits(edge_record_t)),
		.DEPTH     (EDGE_FIFO_DEPTH),
		.ALFULL_GAP(LINE_EDGES)
	) u_edge_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (asm_push),
		.data_in (asm_record),
		.pop     (edge_request),
		.data_out(edge_head),
		.valid   (edge_valid),
		.empty   (),
		.alfull  (edge_alfull)
	);

	assign {edge_id, edge_src, edge_dest, edge_weight} = edge_head;

endmodule

`default_nettype wire

// File: sim/edge_mem_responder.sv
/*
 * memory model for the edge job unit testbench
 *   array images loaded from the test data file
 *   accepts read commands, answers after 1 to 8 cycles
 *   responses leave in shuffled order, one per cycle
 */
`timescale 1ns/1ns
`default_nettype none

module edge_mem_responder (
	input  wire                       clock,
	input  wire                       rstn,
	input  wire                       read_cmd_valid,
	input  wire edge_pkg::addr_t      read_cmd_addr,
	input  wire edge_pkg::array_sel_t read_cmd_array,
	input  wire edge_pkg::addr_t      src_base,
	input  wire edge_pkg::addr_t      dest_base,
	input  wire edge_pkg::addr_t      weight_base,
	output logic                      read_resp_valid,
	output edge_pkg::array_sel_t      read_resp_array,
	output edge_pkg::line_t           read_resp_data
);
	import edge_pkg::*;

	localparam int SLOTS = 4;

	logic [31:0] image [0:255];
	logic        pend_valid [SLOTS];
	array_sel_t  pend_array [SLOTS];
	addr_t       pend_addr [SLOTS];
	int          pend_due [SLOTS];
	int          cycle;
	logic [31:0] rnd;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// four words of one array image, entry 0 lowest
	function automatic line_t read_line(input array_sel_t arr, input addr_t addr);
		addr_t base;
		int    word;
		line_t line;
		case (arr)
			ARRAY_DEST:   base = dest_base;
			ARRAY_WEIGHT: base = weight_base;
			default:      base = src_base;
		endcase
		word = int'((addr - base) >> 2);
		for (int j = 0; j < LINE_EDGES; j++)
			line[j*32 +: 32] = image[int'(arr) * 32 + ((word + j) & 31)];
		return line;
	endfunction

	initial begin
		$readmemh("sim/edge_tests.mem", image);
		read_resp_valid = 1'b0;
		read_resp_array = ARRAY_SRC;
		read_resp_data  = '0;
		rnd             = 32'h4e82;
		cycle           = 0;
		for (int i = 0; i < SLOTS; i++)
			pend_valid[i] = 1'b0;
	end

	// take a command into a free slot with a random due cycle
	always @(posedge clock) begin
		logic placed;
		placed = 1'b0;
		cycle  = cycle + 1;
		if (rstn && read_cmd_valid) begin
			rnd = xorshift(rnd);
			for (int i = 0; i < SLOTS; i++) begin
				if (!placed && !pend_valid[i]) begin
					pend_valid[i] = 1'b1;
					pend_array[i] = read_cmd_array;
					pend_addr[i]  = read_cmd_addr;
					pend_due[i]   = cycle + 1 + int'(rnd % 8);
					placed        = 1'b1;
				end
			end
		end
	end

	// one due response per cycle, scan starts at a random slot
	always @(negedge clock) begin
		int   start;
		int   s;
		logic sent;
		sent            = 1'b0;
		read_resp_valid = 1'b0;
		rnd             = xorshift(rnd);
		start           = int'(rnd % SLOTS);
		for (int j = 0; j < SLOTS; j++) begin
			s = (start + j) % SLOTS;
			if (!sent && pend_valid[s] && pend_due[s] <= cycle) begin
				read_resp_valid = 1'b1;
				read_resp_array = pend_array[s];
				read_resp_data  = read_line(pend_array[s], pend_addr[s]);
				pend_valid[s]   = 1'b0;
				sent            = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_edge_job_control.sv
/*
 * testbench for the edge job unit
 *   clock, reset and vertex jobs from the test data file
 *   edge popping with random gaps, random memory stalls
 *   edge, command and idle checks, timeout and report
 */
`timescale 1ns/1ns
`default_nettype none

module tb_edge_job_control;
	import edge_pkg::*;

	localparam int JOBS     = 8;
	localparam int BASE_POS = 96;
	localparam int JOB_POS  = 100;
	localparam int EXP_POS  = 124;
	// long enough for a stray chunk to reach the edge queue
	localparam int SETTLE   = 40;

	logic         clock;
	logic         rstn;
	logic         vertex_valid;
	edge_count_t  vertex_id;
	edge_count_t  vertex_edge_idx;
	edge_count_t  vertex_degree;
	addr_t        src_base, dest_base, weight_base;
	logic         mem_busy;
	logic         read_resp_valid;
	array_sel_t   read_resp_array;
	line_t        read_resp_data;
	logic         edge_request;
	logic         idle;
	logic         read_cmd_valid;
	addr_t        read_cmd_addr;
	array_sel_t   read_cmd_array;
	logic         edge_valid;
	edge_id_t     edge_id;
	edge_word_t   edge_src, edge_dest, edge_weight;

	logic [31:0]  tests [0:255];
	int           errors;
	int           checks;
	int           cycle_limit;
	logic         limit_set;
	int           cur_idx;
	int           cur_deg;

	edge_job_control DUT (.*);

	edge_mem_responder responder (
		.clock          (clock),
		.rstn           (rstn),
		.read_cmd_valid (read_cmd_valid),
		.read_cmd_addr  (read_cmd_addr),
		.read_cmd_array (read_cmd_array),
		.src_base       (src_base),
		.dest_base      (dest_base),
		.weight_base    (weight_base),
		.read_resp_valid(read_resp_valid),
		.read_resp_array(read_resp_array),
		.read_resp_data (read_resp_data)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			$display("error: %s", what);
			errors++;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// memory stalls on about one cycle in four
	initial begin
		logic [31:0] st;
		st       = xorshift(xorshift(32'h4e82));
		mem_busy = 1'b0;
		forever begin
			@(negedge clock);
			st       = xorshift(st);
			mem_busy = rstn && (st[1:0] == 2'b00);
		end
	end

	initial begin
		wait (limit_set === 1'b1);
		repeat (cycle_limit) @(posedge clock);
		$display("timeout: run went past %0d cycles", cycle_limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	// command monitor
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		addr_t base;
		addr_t off;
		int    lo;
		int    hi;
		if (rstn && read_cmd_valid) begin
			case (read_cmd_array)
				ARRAY_SRC:    base = src_base;
				ARRAY_DEST:   base = dest_base;
				default:      base = weight_base;
			endcase
			off = read_cmd_addr - base;
			lo  = (cur_idx * EDGE_BYTES) / LINE_BYTES * LINE_BYTES;
			hi  = (cur_idx + cur_deg - 1) * EDGE_BYTES;
			check_true(!mem_busy, "read command issued while memory busy");
			check_true(read_cmd_array != 2'd3, "read command with unknown array");
			check_true(off % LINE_BYTES == 0, "read command address not line aligned");
			check_true(int'(off) >= lo && int'(off) <= hi, "read command outside job range");
		end
	end

	//////////////////////////////////////////////////
	// jobs and edge popping
	//////////////////////////////////////////////////
	initial begin
		int          n_exp;
		int          popped;
		int          gap;
		int          exp_pos;
		int          idx;
		int          start_err;
		logic        have_last;
		edge_count_t last_id;
		edge_count_t vid;
		logic [31:0] rnd;

		rstn            = 1'b0;
		vertex_valid    = 1'b0;
		vertex_id       = '0;
		vertex_edge_idx = '0;
		vertex_degree   = '0;
		edge_request    = 1'b0;
		errors          = 0;
		checks          = 0;
		cur_idx         = 0;
		cur_deg         = 0;
		have_last       = 1'b0;
		last_id         = '0;
		exp_pos         = 0;
		rnd             = 32'h4e82;
		$readmemh("sim/edge_tests.mem", tests);
		src_base    = tests[BASE_POS];
		dest_base   = tests[BASE_POS + 1];
		weight_base = tests[BASE_POS + 2];
		cycle_limit = 200 * int'(tests[BASE_POS + 3]);
		limit_set   = 1'b1;

		repeat (5) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_true(idle, "idle low after reset");
		check_true(!edge_valid, "edge_valid high after reset");
		check_true(!read_cmd_valid, "read_cmd_valid high after reset");

		for (int j = 0; j < JOBS; j++) begin
			vid       = tests[JOB_POS + 3*j][15:0];
			idx       = int'(tests[JOB_POS + 3*j + 1]);
			start_err = errors;
			while (!idle)
				@(negedge clock);
			cur_idx         = idx;
			cur_deg         = int'(tests[JOB_POS + 3*j + 2]);
			vertex_id       = vid;
			vertex_edge_idx = edge_count_t'(idx);
			vertex_degree   = edge_count_t'(cur_deg);
			vertex_valid    = 1'b1;
			@(negedge clock);
			vertex_valid = 1'b0;
			// a repeated id is ignored
			n_exp = (have_last && vid == last_id) ? 0 : cur_deg;
			if (have_last && vid == last_id)
				check_true(idle, "repeated vertex id was accepted");
			if (n_exp != 0 || !(have_last && vid == last_id)) begin
				have_last = 1'b1;
				last_id   = vid;
			end
			popped = 0;
			gap    = int'(rnd % 4);
			while (popped < n_exp) begin
				edge_request = 1'b0;
				if (edge_valid && gap == 0) begin
					check_value("edge_id", 32'(exp_pos), 32'(edge_id));
					check_value("edge_src", tests[EXP_POS + 3*exp_pos], edge_src);
					check_value("edge_dest", tests[EXP_POS + 3*exp_pos + 1], edge_dest);
					check_value("edge_weight", tests[EXP_POS + 3*exp_pos + 2], edge_weight);
					// same edge straight from the array images
					check_value("edge_src", tests[idx + popped], edge_src);
					check_value("edge_dest", tests[32 + idx + popped], edge_dest);
					check_value("edge_weight", tests[64 + idx + popped], edge_weight);
					edge_request = 1'b1;
					popped++;
					exp_pos++;
					rnd = xorshift(rnd);
					gap = int'(rnd % 4);
				end else if (gap > 0) begin
					gap--;
				end
				@(negedge clock);
			end
			edge_request = 1'b0;
			while (!idle)
				@(negedge clock);
			repeat (SETTLE) @(negedge clock);
			check_true(!edge_valid, "extra edge after the end of a job");
			check_true(idle, "idle dropped with no job offered");
			$display("job %0d: vertex %h, %0d edges popped, %s", j, vid, popped,
				(errors == start_err) ? "ok" : "errors");
		end

		$display("jobs %0d, checks %0d, errors %0d", JOBS, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: edge_job_control.f
src/edge_pkg.sv
src/sync_fifo.sv
src/edge_request_gen.sv
src/cacheline_unpacker.sv
src/edge_assembler.sv
src/edge_job_control.sv
sim/edge_mem_responder.sv
sim/tb_edge_job_control.sv

// File: sim/edge_tests.mem
// words 0-95: src, dest and weight images, 32 entries each
// then bases, expected edge count, jobs (id idx degree), expected edges (src dest weight)
0a000000 0a000001 0a000002 0a000003 0a000004 0a000005 0a000006 0a000007
0a000008 0a000009 0a00000a 0a00000b 0a00000c 0a00000d 0a00000e 0a00000f
0a000010 0a000011 0a000012 0a000013 0a000014 0a000015 0a000016 0a000017
0a000018 0a000019 0a00001a 0a00001b 0a00001c 0a00001d 0a00001e 0a00001f
0b000000 0b000001 0b000002 0b000003 0b000004 0b000005 0b000006 0b000007
0b000008 0b000009 0b00000a 0b00000b 0b00000c 0b00000d 0b00000e 0b00000f
0b000010 0b000011 0b000012 0b000013 0b000014 0b000015 0b000016 0b000017
0b000018 0b000019 0b00001a 0b00001b 0b00001c 0b00001d 0b00001e 0b00001f
0c000000 0c000001 0c000002 0c000003 0c000004 0c000005 0c000006 0c000007
0c000008 0c000009 0c00000a 0c00000b 0c00000c 0c00000d 0c00000e 0c00000f
0c000010 0c000011 0c000012 0c000013 0c000014 0c000015 0c000016 0c000017
0c000018 0c000019 0c00001a 0c00001b 0c00001c 0c00001d 0c00001e 0c00001f
// src, dest, weight base and edge count
00001000 00002000 00003000 0000001f
// jobs
00000001 00000000 00000004
00000002 00000004 00000008
00000002 0000000c 00000003
00000003 0000000d 00000006
00000004 00000016 00000001
00000005 00000019 00000007
00000006 00000000 00000000
00000007 00000009 00000005
// expected edges, two per line
0a000000 0b000000 0c000000 0a000001 0b000001 0c000001
0a000002 0b000002 0c000002 0a000003 0b000003 0c000003
0a000004 0b000004 0c000004 0a000005 0b000005 0c000005
0a000006 0b000006 0c000006 0a000007 0b000007 0c000007
0a000008 0b000008 0c000008 0a000009 0b000009 0c000009
0a00000a 0b00000a 0c00000a 0a00000b 0b00000b 0c00000b
0a00000d 0b00000d 0c00000d 0a00000e 0b00000e 0c00000e
0a00000f 0b00000f 0c00000f 0a000010 0b000010 0c000010
0a000011 0b000011 0c000011 0a000012 0b000012 0c000012
0a000016 0b000016 0c000016 0a000019 0b000019 0c000019
0a00001a 0b00001a 0c00001a 0a00001b 0b00001b 0c00001b
0a00001c 0b00001c 0c00001c 0a00001d 0b00001d 0c00001d
0a00001e 0b00001e 0c00001e 0a00001f 0b00001f 0c00001f
0a000009 0b000009 0c000009 0a00000a 0b00000a 0c00000a
0a00000b 0b00000b 0c00000b 0a00000c 0b00000c 0c00000c
0a00000d 0b00000d 0c00000d
